// ==== sources.f ====
+incdir+source
source/cacheCtlPkg.sv
source/requestArbiter.sv
source/cycleSequencer.sv
source/lookupEvaluator.sv
source/outcomeDiag.sv
source/cacheCtlTop.sv
tb/clockGen.sv
tb/cacheCtlTb.sv

// ==== Bender.yml ====
package:
  name: cacheCtl

sources:
  - include_dirs:
      - source
    files:
      - source/cacheCtlPkg.sv
      - source/requestArbiter.sv
      - source/cycleSequencer.sv
      - source/lookupEvaluator.sv
      - source/outcomeDiag.sv
      - source/cacheCtlTop.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/cacheCtlTb.sv

// ==== tb/cacheCtlTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cacheCtlTb;

  typedef struct {
    string                 name;
    cacheCtlPkg::request_t req;
    bit                    lead;
    bit                    busy;
    bit                    abort;
    cacheCtlPkg::lookup_t  lookup;
    logic [15:0]           mask;
    cacheCtlPkg::outcome_t outcome;
    cacheCtlPkg::wayIdx_t  victim;
  } caseEntry_t;

  logic                    clk;
  logic                    rstN;
  cacheCtlPkg::request_t   req;
  logic                    coreBusy;
  logic                    eboxAbort;
  cacheCtlPkg::lookup_t    lookup;
  cacheCtlPkg::diagSel_t   diagSel;
  cacheCtlPkg::result_t    result;
  cacheCtlPkg::cycleType_t cycleType;
  logic                    readyToGo;
  cacheCtlPkg::diagByte_t  diagByte;

  caseEntry_t cases[$];
  int checks = 0;
  int mismatches = 0;
  int timeouts = 0;

  clockGen u_clockGen (
    .clk  (clk),
    .rstN (rstN)
  );

  cacheCtlTop u_dut (
    .clk       (clk),
    .rstN      (rstN),
    .req       (req),
    .coreBusy  (coreBusy),
    .eboxAbort (eboxAbort),
    .lookup    (lookup),
    .diagSel   (diagSel),
    .result    (result),
    .cycleType (cycleType),
    .readyToGo (readyToGo),
    .diagByte  (diagByte)
  );

  function automatic void addCase(input string name, input cacheCtlPkg::request_t r,
      input bit lead, input bit busy, input bit abort, input cacheCtlPkg::lookup_t lk,
      input logic [15:0] mask, input cacheCtlPkg::outcome_t out, input cacheCtlPkg::wayIdx_t way);
    caseEntry_t e;
    e.name    = name;
    e.req     = r;
    e.lead    = lead;
    e.busy    = busy;
    e.abort   = abort;
    e.lookup  = lk;
    e.mask    = mask;
    e.outcome = out;
    e.victim  = way;
    cases.push_back(e);
  endfunction

  // Fixed priority, memory buffer seen one edge late, EBOX held off while busy
  function automatic cacheCtlPkg::cycleType_t expectedGrant(input caseEntry_t c, input int k);
    bit othersSeen;
    othersSeen = !c.lead || k >= 2;
    if (c.req.mbReq && k >= 2) return cacheCtlPkg::cycMb;
    if (othersSeen && c.req.chanReq) return cacheCtlPkg::cycChan;
    if (othersSeen && c.req.eboxReq && !(c.busy && k <= 3)) return cacheCtlPkg::cycEbox;
    if (othersSeen && c.req.ccaReq) return cacheCtlPkg::cycCca;
    return cacheCtlPkg::cycIdle;
  endfunction

  task automatic checkValue(input string name, input string what,
      input logic [15:0] exp, input logic [15:0] act);
    checks++;
    assert (act === exp) else begin
      mismatches++;
      $display("mismatch %s %s: expected %0h, actual %0h", name, what, exp, act);
    end
  endtask

  task automatic waitReady(input string name);
    int cnt;
    cnt = 0;
    @(posedge clk);
    #5;
    while (readyToGo !== 1'b1 && cnt < 20) begin
      @(posedge clk);
      #5;
      cnt++;
    end
    assert (readyToGo === 1'b1) else begin
      timeouts++;
      $display("%s: readyToGo never came back high", name);
    end
  endtask

  task automatic checkDiag(input string name, input cacheCtlPkg::lookup_t lk,
      input cacheCtlPkg::outcome_t out, input cacheCtlPkg::wayIdx_t way);
    diagSel = 3'd1;
    #1;
    checkValue(name, "diag 1", {lk.wayWritten, lk.wayMatch}, diagByte);
    diagSel = 3'd2;
    #1;
    checkValue(name, "diag 2", {2'b00, lk.lruWay, lk.wordValid}, diagByte);
    diagSel = 3'd3;
    #1;
    checkValue(name, "diag 3", {2'b00, way, out}, diagByte);
    diagSel = 3'd5;
    #1;
    checkValue(name, "diag 5", 16'h0000, diagByte);
    diagSel = 3'd0;
  endtask

  task automatic runCase(input caseEntry_t c);
    int k;
    int grantEdge;
    logic [31:0] rnd;
    cacheCtlPkg::lookup_t lk;
    waitReady(c.name);
    rnd = $urandom;
    // Fields the rules ignore get random values
    lk = (c.lookup & ~c.mask) | (rnd[15:0] & c.mask);
    lookup = lk;
    coreBusy = c.busy;
    req = c.lead ? (c.req & 4'b1000) : c.req;
    k = 0;
    grantEdge = 0;
    while (result.done !== 1'b1 && k < 12) begin
      @(posedge clk);
      #5;
      k++;
      if (grantEdge == 0) begin
        checkValue(c.name, "cycleType", expectedGrant(c, k), cycleType);
        if (cycleType != cacheCtlPkg::cycIdle) begin
          grantEdge = k;
          req = '0;
          // Status byte 0 right after the grant shows T0
          checkValue(c.name, "diag 0", {2'b00, cacheCtlPkg::tT0, expectedGrant(c, k)},
              diagByte);
        end else begin
          if (k == 1 && c.lead) req = c.req;
          if (k == 3) coreBusy = 1'b0;
        end
      end else begin
        checkValue(c.name, "readyToGo busy", 16'h0, readyToGo);
        // Abort is driven while the cycle sits in T1
        eboxAbort = c.abort && (k == grantEdge + 1);
      end
    end
    assert (result.done === 1'b1) else begin
      timeouts++;
      $display("%s: done never came", c.name);
    end
    checkValue(c.name, "done edge", grantEdge + 3, k);
    checkValue(c.name, "outcome", c.outcome, result.outcome);
    checkValue(c.name, "victimWay", c.victim, result.victimWay);
    eboxAbort = 1'b0;
    coreBusy = 1'b0;
    @(posedge clk);
    #5;
    checkValue(c.name, "done after T3", 16'h0, result.done);
    checkValue(c.name, "readyToGo after T3", 16'h1, readyToGo);
    checkDiag(c.name, lk, c.outcome, c.victim);
  endtask

  initial begin
    int cnt;
    void'($urandom(32'h9ebf));
    req = '0;
    coreBusy = 1'b0;
    eboxAbort = 1'b0;
    lookup = '0;
    diagSel = '0;

    // Name, request, mb first, busy, abort, lookup, random mask, outcome, victim
    // Lookup nibbles are wayMatch, wayWritten, wordValid, then lruWay, isWrite, cacheable
    addCase("mbFill", 4'b1000, 0, 0, 0, 16'h200D, 16'h0FF3, cacheCtlPkg::outFill, 1);
    addCase("chanHit", 4'b0100, 0, 0, 0, 16'h4001, 16'h0FF3, cacheCtlPkg::outChanHit, 2);
    addCase("chanMiss", 4'b0100, 0, 0, 0, 16'h000D, 16'h0FF3, cacheCtlPkg::outChanMiss, 3);
    addCase("ccaDirty", 4'b0001, 0, 0, 0, 16'h8801, 16'h00F3, cacheCtlPkg::outWriteback, 3);
    addCase("ccaInval", 4'b0001, 0, 0, 0, 16'h2D01, 16'h00F3, cacheCtlPkg::outInvalidate, 1);
    addCase("ccaClean", 4'b0001, 0, 0, 0, 16'h0F09, 16'h00F3, cacheCtlPkg::outSweepClean, 2);
    addCase("rdHit", 4'b0010, 0, 0, 0, 16'h4041, 16'h0F01, cacheCtlPkg::outReadHit, 2);
    addCase("rdNoWord", 4'b0010, 0, 0, 0, 16'h40B1, 16'h0F01, cacheCtlPkg::outCoreRead, 2);
    addCase("rdUncached", 4'b0010, 0, 0, 0, 16'h0F04, 16'h0FF0, cacheCtlPkg::outCoreRead, 1);
    addCase("rdDirtyLru", 4'b0010, 0, 0, 0, 16'h0409, 16'h00F0, cacheCtlPkg::outWriteback, 2);
    addCase("rdMiss", 4'b0010, 0, 0, 0, 16'h0B09, 16'h00F0, cacheCtlPkg::outCoreRead, 2);
    addCase("wrHit", 4'b0010, 0, 0, 0, 16'hA003, 16'h0FF1, cacheCtlPkg::outWriteHit, 1);
    addCase("wrThru", 4'b0010, 0, 0, 0, 16'h000E, 16'h0FF0, cacheCtlPkg::outWriteThrough, 3);
    addCase("wrDirtyLru", 4'b0010, 0, 0, 0, 16'h0103, 16'h00F0, cacheCtlPkg::outWriteback, 0);
    addCase("wrAlloc", 4'b0010, 0, 0, 0, 16'h0E03, 16'h00F0, cacheCtlPkg::outAllocate, 0);
    addCase("eboxAbort", 4'b0010, 0, 0, 1, 16'h1019, 16'h0FF3, cacheCtlPkg::outAborted, 0);
    addCase("chanAbort", 4'b0100, 0, 0, 1, 16'h4001, 16'h0FF3, cacheCtlPkg::outChanHit, 2);
    addCase("chanFirst", 4'b0111, 0, 0, 0, 16'h1001, 16'h0FF3, cacheCtlPkg::outChanHit, 0);
    addCase("eboxFirst", 4'b0011, 0, 0, 0, 16'h4041, 16'h0F01, cacheCtlPkg::outReadHit, 2);
    addCase("mbLate", 4'b1100, 0, 0, 0, 16'h000D, 16'h0FF3, cacheCtlPkg::outChanMiss, 3);
    addCase("mbFirst", 4'b1100, 1, 0, 0, 16'h000D, 16'h0FF3, cacheCtlPkg::outFill, 3);
    addCase("eboxBusy", 4'b0010, 0, 1, 0, 16'h0E03, 16'h00F0, cacheCtlPkg::outAllocate, 0);
    addCase("busyCca", 4'b0011, 0, 1, 0, 16'h0F09, 16'h00F3, cacheCtlPkg::outSweepClean, 2);

    cnt = 0;
    while (rstN !== 1'b1 && cnt < 10) begin
      @(posedge clk);
      cnt++;
    end
    assert (rstN === 1'b1) else begin
      timeouts++;
      $display("reset was never released");
    end
    #5;
    checkValue("reset", "readyToGo", 16'h1, readyToGo);
    checkValue("reset", "cycleType", cacheCtlPkg::cycIdle, cycleType);
    checkValue("reset", "done", 16'h0, result.done);
    checkValue("reset", "outcome", cacheCtlPkg::outNone, result.outcome);

    foreach (cases[i]) begin
      runCase(cases[i]);
    end

    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
  parameter int HalfPeriod  = 50,
  parameter int ResetCycles = 3
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever begin
      #HalfPeriod clk = ~clk;
    end
  end

  // Reset released just after an edge
  initial begin
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #5;
    rstN = 1'b1;
  end

endmodule

`default_nettype wire

// ==== source/cacheCtlTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module cacheCtlTop (
  input  wire logic                   clk,
  input  wire logic                   rstN,
  input  wire cacheCtlPkg::request_t  req,
  input  wire logic                   coreBusy,
  input  wire logic                   eboxAbort,
  input  wire cacheCtlPkg::lookup_t   lookup,
  input  wire cacheCtlPkg::diagSel_t  diagSel,
  output cacheCtlPkg::result_t        result,
  output cacheCtlPkg::cycleType_t     cycleType,
  output logic                        readyToGo,
  output cacheCtlPkg::diagByte_t      diagByte
);

  cacheCtlPkg::cycleType_t grant;
  cacheCtlPkg::tState_t    tState;
  logic                    aborted;
  cacheCtlPkg::outcome_t   outcome;
  cacheCtlPkg::wayIdx_t    victimWay;

  requestArbiter u_requestArbiter (
    .clk       (clk),
    .rstN      (rstN),
    .req       (req),
    .coreBusy  (coreBusy),
    .readyToGo (readyToGo),
    .grant     (grant)
  );

  cycleSequencer u_cycleSequencer (
    .clk       (clk),
    .rstN      (rstN),
    .grant     (grant),
    .eboxAbort (eboxAbort),
    .cycleType (cycleType),
    .tState    (tState),
    .aborted   (aborted),
    .readyToGo (readyToGo)
  );

  lookupEvaluator u_lookupEvaluator (
    .cycleType (cycleType),
    .aborted   (aborted),
    .lookup    (lookup),
    .outcome   (outcome),
    .victimWay (victimWay)
  );

  outcomeDiag u_outcomeDiag (
    .clk       (clk),
    .rstN      (rstN),
    .tState    (tState),
    .cycleType (cycleType),
    .outcome   (outcome),
    .victimWay (victimWay),
    .lookup    (lookup),
    .diagSel   (diagSel),
    .result    (result),
    .diagByte  (diagByte)
  );

endmodule

`default_nettype wire

// ==== source/outcomeDiag.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cacheCtl_defines.svh"

module outcomeDiag (
  input  wire logic                     clk,
  input  wire logic                     rstN,
  input  wire cacheCtlPkg::tState_t     tState,
  input  wire cacheCtlPkg::cycleType_t  cycleType,
  input  wire cacheCtlPkg::outcome_t    outcome,
  input  wire cacheCtlPkg::wayIdx_t     victimWay,
  input  wire cacheCtlPkg::lookup_t     lookup,
  input  wire cacheCtlPkg::diagSel_t    diagSel,
  output cacheCtlPkg::result_t          result,
  output cacheCtlPkg::diagByte_t        diagByte
);

  localparam int PadW = `DIAG_W - 6;

  // Decision captured leaving T2, done marks T3
  always_ff @(posedge clk) begin
    if (!rstN) begin
      result.outcome   <= cacheCtlPkg::outNone;
      result.victimWay <= '0;
      result.done      <= 1'b0;
    end else begin
      result.done <= (tState == cacheCtlPkg::tT2);
      if (tState == cacheCtlPkg::tT2) begin
        result.outcome   <= outcome;
        result.victimWay <= victimWay;
      end
    end
  end

  always_comb begin
    case (diagSel)
      3'd0: diagByte = {{PadW{1'b0}}, tState, cycleType};
      3'd1: diagByte = {lookup.wayWritten, lookup.wayMatch};
      3'd2: diagByte = {{PadW{1'b0}}, lookup.lruWay, lookup.wordValid};
      // Last outcome and victim
      3'd3: diagByte = {{PadW{1'b0}}, result.victimWay, result.outcome};
      default: diagByte = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/lookupEvaluator.sv ====
`timescale 1ns/1ns
`default_nettype none

module lookupEvaluator (
  input  wire cacheCtlPkg::cycleType_t  cycleType,
  input  wire logic                     aborted,
  input  wire cacheCtlPkg::lookup_t     lookup,
  output cacheCtlPkg::outcome_t         outcome,
  output cacheCtlPkg::wayIdx_t          victimWay
);

  logic anyValidMatch;
  logic readFound;
  logic anyWrittenMatch;
  logic lruWritten;

  // Four-way reductions
  assign anyValidMatch   = |lookup.wayMatch;
  assign readFound       = |(lookup.wayMatch & lookup.wordValid);
  assign anyWrittenMatch = |(lookup.wayMatch & lookup.wayWritten);
  assign lruWritten      = lookup.wayWritten[lookup.lruWay];

  // Lowest matching way, else the LRU way
  always_comb begin
    victimWay = lookup.lruWay;
    for (int i = $bits(lookup.wayMatch) - 1; i >= 0; i--) begin
      if (lookup.wayMatch[i]) begin
        victimWay = cacheCtlPkg::wayIdx_t'(i);
      end
    end
  end

  always_comb begin
    outcome = cacheCtlPkg::outNone;
    if (aborted) begin
      outcome = cacheCtlPkg::outAborted;
    end else begin
      case (cycleType)
        cacheCtlPkg::cycMb: begin
          outcome = cacheCtlPkg::outFill;
        end
        cacheCtlPkg::cycChan: begin
          outcome = anyValidMatch ? cacheCtlPkg::outChanHit : cacheCtlPkg::outChanMiss;
        end
        cacheCtlPkg::cycCca: begin
          if (anyWrittenMatch) begin
            outcome = cacheCtlPkg::outWriteback;
          end else if (anyValidMatch) begin
            outcome = cacheCtlPkg::outInvalidate;
          end else begin
            outcome = cacheCtlPkg::outSweepClean;
          end
        end
        cacheCtlPkg::cycEbox: begin
          if (!lookup.isWrite) begin
            if (readFound) begin
              outcome = cacheCtlPkg::outReadHit;
            end else if (anyValidMatch || !lookup.cacheable) begin
              outcome = cacheCtlPkg::outCoreRead;
            end else if (lruWritten) begin
              outcome = cacheCtlPkg::outWriteback;
            end else begin
              outcome = cacheCtlPkg::outCoreRead;
            end
          end else begin
            if (anyValidMatch) begin
              outcome = cacheCtlPkg::outWriteHit;
            end else if (!lookup.cacheable) begin
              outcome = cacheCtlPkg::outWriteThrough;
            end else if (lruWritten) begin
              outcome = cacheCtlPkg::outWriteback;
            end else begin
              outcome = cacheCtlPkg::outAllocate;
            end
          end
        end
        default: begin
          outcome = cacheCtlPkg::outNone;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/cycleSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module cycleSequencer (
  input  wire logic                     clk,
  input  wire logic                     rstN,
  input  wire cacheCtlPkg::cycleType_t  grant,
  input  wire logic                     eboxAbort,
  output cacheCtlPkg::cycleType_t       cycleType,
  output cacheCtlPkg::tState_t          tState,
  output logic                          aborted,
  output logic                          readyToGo
);

  // Cycle type and timing chain
  always_ff @(posedge clk) begin
    if (!rstN) begin
      cycleType <= cacheCtlPkg::cycIdle;
      tState    <= cacheCtlPkg::tIdle;
      aborted   <= 1'b0;
    end else begin
      case (tState)
        cacheCtlPkg::tIdle: begin
          if (grant != cacheCtlPkg::cycIdle) begin
            cycleType <= grant;
            tState    <= cacheCtlPkg::tT0;
            aborted   <= 1'b0;
          end
        end
        cacheCtlPkg::tT0: begin
          tState <= cacheCtlPkg::tT1;
        end
        cacheCtlPkg::tT1: begin
          tState <= cacheCtlPkg::tT2;
          // Only an EBOX cycle can be aborted
          if (cycleType == cacheCtlPkg::cycEbox && eboxAbort) begin
            aborted <= 1'b1;
          end
        end
        cacheCtlPkg::tT2: begin
          tState <= cacheCtlPkg::tT3;
        end
        cacheCtlPkg::tT3: begin
          tState    <= cacheCtlPkg::tIdle;
          cycleType <= cacheCtlPkg::cycIdle;
        end
        default: begin
          tState    <= cacheCtlPkg::tIdle;
          cycleType <= cacheCtlPkg::cycIdle;
        end
      endcase
    end
  end

  assign readyToGo = (tState == cacheCtlPkg::tIdle);

endmodule

`default_nettype wire

// ==== source/requestArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module requestArbiter (
  input  wire logic                   clk,
  input  wire logic                   rstN,
  input  wire cacheCtlPkg::request_t  req,
  input  wire logic                   coreBusy,
  input  wire logic                   readyToGo,
  output cacheCtlPkg::cycleType_t     grant
);

  logic mbReqQ;
  logic eboxReqEn;

  // Memory buffer request arrives through a flop
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mbReqQ <= 1'b0;
    end else begin
      mbReqQ <= req.mbReq;
    end
  end

  // Core busy holds off the EBOX only
  assign eboxReqEn = ~coreBusy;

  always_comb begin
    grant = cacheCtlPkg::cycIdle;
    if (readyToGo) begin
      if (mbReqQ) begin
        grant = cacheCtlPkg::cycMb;
      end else if (req.chanReq) begin
        grant = cacheCtlPkg::cycChan;
      end else if (req.eboxReq && eboxReqEn) begin
        grant = cacheCtlPkg::cycEbox;
      end else if (req.ccaReq) begin
        grant = cacheCtlPkg::cycCca;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/cacheCtlPkg.sv ====
`default_nettype none

`include "cacheCtl_defines.svh"

package cacheCtlPkg;

  typedef logic [`CACHE_WAYS-1:0] wayVec_t;
  typedef logic [$clog2(`CACHE_WAYS)-1:0] wayIdx_t;
  typedef logic [`DIAG_SEL_W-1:0] diagSel_t;
  typedef logic [`DIAG_W-1:0] diagByte_t;

  typedef enum logic [2:0] {
    cycIdle,
    cycMb,
    cycChan,
    cycEbox,
    cycCca
  } cycleType_t;

  typedef enum logic [2:0] {
    tIdle,
    tT0,
    tT1,
    tT2,
    tT3
  } tState_t;

  typedef enum logic [3:0] {
    outNone,
    outReadHit,
    outCoreRead,
    outWriteHit,
    outWriteThrough,
    outAllocate,
    outWriteback,
    outChanHit,
    outChanMiss,
    outInvalidate,
    outSweepClean,
    outFill,
    outAborted
  } outcome_t;

  typedef struct packed {
    logic mbReq;
    logic chanReq;
    logic eboxReq;
    logic ccaReq;
  } request_t;

  // Held by the environment from grant to done
  typedef struct packed {
    wayVec_t wayMatch;
    wayVec_t wayWritten;
    wayVec_t wordValid;
    wayIdx_t lruWay;
    logic isWrite;
    logic cacheable;
  } lookup_t;

  typedef struct packed {
    outcome_t outcome;
    wayIdx_t victimWay;
    logic done;
  } result_t;

endpackage

`default_nettype wire

// ==== source/cacheCtl_defines.svh ====
`ifndef CACHE_CTL_DEFINES_SVH
`define CACHE_CTL_DEFINES_SVH

// Cache geometry
`define CACHE_WAYS 4

// Diagnostic readout
`define DIAG_SEL_W 3
`define DIAG_W 8

`endif
